// File: rtl/lc3b_types.sv
package lc3b_types;

// Datum, address and register index
typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

// Full LC-3b opcode map, IR[15:12]
typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} alu_ops;

// ALU operand b
typedef enum logic [1:0] {
	alumux_sr2   = 2'b00,
	alumux_off6w = 2'b01,
	alumux_imm5  = 2'b10,
	alumux_off6b = 2'b11
} alumux_sel_t;

// Writeback source
typedef enum logic [1:0] {
	rfmux_alu = 2'b00,
	rfmux_mem = 2'b01,
	rfmux_lea = 2'b10,
	rfmux_shf = 2'b11
} regfilemux_sel_t;

// Travels with the instruction from decode into execute
typedef struct packed {
	lc3b_opcode opcode;
	alu_ops alu_op;
	alumux_sel_t alumux_sel;
	regfilemux_sel_t regfilemux_sel;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic byte_access;
	logic is_branch;
} lc3b_control_word;

endpackage : lc3b_types

// File: rtl/control_rom.sv
module control_rom (
	input lc3b_types::lc3b_word inst,
	output lc3b_types::lc3b_control_word ctrl
);

	import lc3b_types::*;

	always_comb begin
		// Defaults describe a no-op
		ctrl.opcode = lc3b_opcode'(inst[15:12]);
		ctrl.alu_op = alu_add;
		ctrl.alumux_sel = alumux_sr2;
		ctrl.regfilemux_sel = rfmux_alu;
		ctrl.load_regfile = 1'b0;
		ctrl.load_cc = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.byte_access = 1'b0;
		ctrl.is_branch = 1'b0;

		case (lc3b_opcode'(inst[15:12]))
			op_add: begin
				ctrl.alu_op = alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				// Immediate form
				if (inst[5])
					ctrl.alumux_sel = alumux_imm5;
			end

			op_and: begin
				ctrl.alu_op = alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				if (inst[5])
					ctrl.alumux_sel = alumux_imm5;
			end

			op_not: begin
				ctrl.alu_op = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_ldr: begin
				// Address is BaseR + offset6 words
				ctrl.alumux_sel = alumux_off6w;
				ctrl.alu_op = alu_add;
				ctrl.mem_read = 1'b1;
				ctrl.regfilemux_sel = rfmux_mem;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_str: begin
				ctrl.alumux_sel = alumux_off6w;
				ctrl.alu_op = alu_add;
				ctrl.mem_write = 1'b1;
			end

			op_ldb: begin
				// Byte offset, no shift
				ctrl.alumux_sel = alumux_off6b;
				ctrl.alu_op = alu_add;
				ctrl.mem_read = 1'b1;
				ctrl.byte_access = 1'b1;
				ctrl.regfilemux_sel = rfmux_mem;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_stb: begin
				ctrl.alumux_sel = alumux_off6b;
				ctrl.alu_op = alu_add;
				ctrl.mem_write = 1'b1;
				ctrl.byte_access = 1'b1;
			end

			op_br: begin
				// Decision made in execute against cc
				ctrl.is_branch = 1'b1;
			end

			op_shf: begin
				ctrl.regfilemux_sel = rfmux_shf;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_lea: begin
				// PC + offset9 words, from the address adder
				ctrl.regfilemux_sel = rfmux_lea;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			default: begin
				// JMP, JSR, TRAP, LDI, STI, RTI retire as bubbles
				ctrl = '0;
			end
		endcase
	end

endmodule : control_rom

// File: rtl/fetch_stage.sv
module fetch_stage #(
	parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic rst,
	input logic br_taken,
	input lc3b_types::lc3b_word br_target,
	output lc3b_types::lc3b_word imem_addr,
	input lc3b_types::lc3b_word imem_rdata,
	output lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_word ir_pc,
	output logic ir_valid
);

	import lc3b_types::*;

	// Address of the next word to fetch
	lc3b_word pc;
	lc3b_word pc_next;

	// Taken branch steers this cycle's fetch to the target
	assign imem_addr = br_taken ? br_target : pc;
	assign pc_next = imem_addr + 16'd2;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
			ir_valid <= 1'b0;
		end else begin
			pc <= pc_next;
			ir_valid <= 1'b1;
		end
	end

	// Fetched word and its incremented PC
	always_ff @(posedge clk) begin
		ir <= imem_rdata;
		ir_pc <= pc_next;
	end

endmodule : fetch_stage

// File: rtl/regfile.sv
module regfile (
	input logic clk,
	input logic rst,
	input logic we,
	input lc3b_types::lc3b_reg wdest,
	input lc3b_types::lc3b_word wdata,
	input lc3b_types::lc3b_reg ra,
	input lc3b_types::lc3b_reg rb,
	output lc3b_types::lc3b_word da,
	output lc3b_types::lc3b_word db
);

	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wdest] <= wdata;
		end
	end

	// A write in flight is forwarded in decode
	assign da = regs[ra];
	assign db = regs[rb];

endmodule : regfile

// File: rtl/decode_stage.sv
module decode_stage (
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_word ir,
	input lc3b_types::lc3b_word ir_pc,
	input logic ir_valid,
	input logic br_taken,
	output lc3b_types::lc3b_reg rf_ra,
	output lc3b_types::lc3b_reg rf_rb,
	input lc3b_types::lc3b_word rf_da,
	input lc3b_types::lc3b_word rf_db,
	input logic wb_valid,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	output logic ex_valid,
	output lc3b_types::lc3b_control_word ex_ctrl,
	output lc3b_types::lc3b_word ex_pc,
	output lc3b_types::lc3b_word ex_sra,
	output lc3b_types::lc3b_word ex_srb,
	output lc3b_types::lc3b_reg ex_dest,
	output lc3b_types::lc3b_word ex_imm
);

	import lc3b_types::*;

	lc3b_control_word ctrl;
	lc3b_word opa;
	lc3b_word opb;
	lc3b_word imm;

	control_rom rom (
		.inst(ir),
		.ctrl(ctrl)
	);

	// SR1/BaseR always IR[8:6]; stores read their data on port b
	assign rf_ra = ir[8:6];
	assign rf_rb = ctrl.mem_write ? ir[11:9] : ir[2:0];

	// Bypass from the instruction now in execute
	assign opa = (wb_valid && wb_dest == rf_ra) ? wb_data : rf_da;
	assign opb = (wb_valid && wb_dest == rf_rb) ? wb_data : rf_db;

	always_comb begin
		case (ctrl.alumux_sel)
			alumux_off6w: imm = {{9{ir[5]}}, ir[5:0], 1'b0};
			alumux_imm5: imm = {{11{ir[4]}}, ir[4:0]};
			alumux_off6b: imm = {{10{ir[5]}}, ir[5:0]};
			// BR and LEA: offset9 in words
			default: imm = {{6{ir[8]}}, ir[8:0], 1'b0};
		endcase
		// SHF carries A, D and imm4 raw
		if (ctrl.opcode == op_shf)
			imm = {10'b0, ir[5:0]};
	end

	// Squash the slot behind a taken branch
	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= ir_valid && !br_taken;
	end

	always_ff @(posedge clk) begin
		ex_ctrl <= ctrl;
		ex_pc <= ir_pc;
		ex_sra <= opa;
		ex_srb <= opb;
		// Also the nzp field for BR
		ex_dest <= ir[11:9];
		ex_imm <= imm;
	end

endmodule : decode_stage

// File: rtl/execute_stage.sv
module execute_stage (
	input logic clk,
	input logic rst,
	input logic ex_valid,
	input lc3b_types::lc3b_control_word ex_ctrl,
	input lc3b_types::lc3b_word ex_pc,
	input lc3b_types::lc3b_word ex_sra,
	input lc3b_types::lc3b_word ex_srb,
	input lc3b_types::lc3b_reg ex_dest,
	input lc3b_types::lc3b_word ex_imm,
	output lc3b_types::lc3b_word dmem_addr,
	output logic dmem_read,
	output logic dmem_write,
	output logic [1:0] dmem_byte_en,
	output lc3b_types::lc3b_word dmem_wdata,
	input lc3b_types::lc3b_word dmem_rdata,
	output logic br_taken,
	output lc3b_types::lc3b_word br_target,
	output logic wb_valid,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output logic [2:0] cc
);

	import lc3b_types::*;

	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word shf_out;
	lc3b_word addr_sum;
	lc3b_word load_val;

	assign alu_b = (ex_ctrl.alumux_sel == alumux_sr2) ? ex_srb : ex_imm;

	always_comb begin
		case (ex_ctrl.alu_op)
			alu_add: alu_out = ex_sra + alu_b;
			alu_and: alu_out = ex_sra & alu_b;
			alu_not: alu_out = ~ex_sra;
			default: alu_out = alu_b;
		endcase
	end

	// imm[4] is D, imm[5] is A
	always_comb begin
		if (!ex_imm[4])
			shf_out = ex_sra << ex_imm[3:0];
		else if (!ex_imm[5])
			shf_out = ex_sra >> ex_imm[3:0];
		else
			shf_out = lc3b_word'($signed(ex_sra) >>> ex_imm[3:0]);
	end

	// LEA value and branch target share one adder
	assign addr_sum = ex_pc + ex_imm;
	assign br_target = addr_sum;

	// Word accesses are forced even
	assign dmem_addr = ex_ctrl.byte_access ? alu_out : {alu_out[15:1], 1'b0};
	assign dmem_read = ex_valid && ex_ctrl.mem_read;
	assign dmem_write = ex_valid && ex_ctrl.mem_write;
	assign dmem_wdata = ex_ctrl.byte_access ? {ex_srb[7:0], ex_srb[7:0]} : ex_srb;

	always_comb begin
		if (!ex_ctrl.byte_access)
			dmem_byte_en = 2'b11;
		else if (alu_out[0])
			dmem_byte_en = 2'b10;
		else
			dmem_byte_en = 2'b01;
	end

	// LDB zero-extends the addressed lane
	always_comb begin
		if (!ex_ctrl.byte_access)
			load_val = dmem_rdata;
		else if (alu_out[0])
			load_val = {8'h00, dmem_rdata[15:8]};
		else
			load_val = {8'h00, dmem_rdata[7:0]};
	end

	always_comb begin
		case (ex_ctrl.regfilemux_sel)
			rfmux_mem: wb_data = load_val;
			rfmux_lea: wb_data = addr_sum;
			rfmux_shf: wb_data = shf_out;
			default: wb_data = alu_out;
		endcase
	end

	assign wb_valid = ex_valid && ex_ctrl.load_regfile;
	assign wb_dest = ex_dest;

	// nzp flags, Z out of reset
	always_ff @(posedge clk) begin
		if (rst)
			cc <= 3'b010;
		else if (ex_valid && ex_ctrl.load_cc)
			cc <= {wb_data[15], wb_data == 16'h0000, !wb_data[15] && wb_data != 16'h0000};
	end

	// BR nzp field sits in the dest slot
	assign br_taken = ex_valid && ex_ctrl.is_branch && (ex_dest & cc) != 3'b000;

endmodule : execute_stage

// File: rtl/lc3b_pipeline.sv
module lc3b_pipeline #(
	parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic rst,
	output lc3b_types::lc3b_word imem_addr,
	input lc3b_types::lc3b_word imem_rdata,
	output lc3b_types::lc3b_word dmem_addr,
	output logic dmem_read,
	output logic dmem_write,
	output logic [1:0] dmem_byte_en,
	output lc3b_types::lc3b_word dmem_wdata,
	input lc3b_types::lc3b_word dmem_rdata,
	output logic wb_valid,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output logic [2:0] cc
);

	import lc3b_types::*;

	// Fetch to decode
	lc3b_word ir;
	lc3b_word ir_pc;
	logic ir_valid;

	// Register file ports
	lc3b_reg rf_ra;
	lc3b_reg rf_rb;
	lc3b_word rf_da;
	lc3b_word rf_db;

	// Decode to execute
	logic ex_valid;
	lc3b_control_word ex_ctrl;
	lc3b_word ex_pc;
	lc3b_word ex_sra;
	lc3b_word ex_srb;
	lc3b_reg ex_dest;
	lc3b_word ex_imm;

	// Redirect
	logic br_taken;
	lc3b_word br_target;

	fetch_stage #(
		.reset_pc(reset_pc)
	) fetch (
		.clk(clk),
		.rst(rst),
		.br_taken(br_taken),
		.br_target(br_target),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.ir(ir),
		.ir_pc(ir_pc),
		.ir_valid(ir_valid)
	);

	decode_stage decode (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.ir_pc(ir_pc),
		.ir_valid(ir_valid),
		.br_taken(br_taken),
		.rf_ra(rf_ra),
		.rf_rb(rf_rb),
		.rf_da(rf_da),
		.rf_db(rf_db),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.ex_valid(ex_valid),
		.ex_ctrl(ex_ctrl),
		.ex_pc(ex_pc),
		.ex_sra(ex_sra),
		.ex_srb(ex_srb),
		.ex_dest(ex_dest),
		.ex_imm(ex_imm)
	);

	// Written by execute at the end of its cycle
	regfile rf (
		.clk(clk),
		.rst(rst),
		.we(wb_valid),
		.wdest(wb_dest),
		.wdata(wb_data),
		.ra(rf_ra),
		.rb(rf_rb),
		.da(rf_da),
		.db(rf_db)
	);

	execute_stage execute (
		.clk(clk),
		.rst(rst),
		.ex_valid(ex_valid),
		.ex_ctrl(ex_ctrl),
		.ex_pc(ex_pc),
		.ex_sra(ex_sra),
		.ex_srb(ex_srb),
		.ex_dest(ex_dest),
		.ex_imm(ex_imm),
		.dmem_addr(dmem_addr),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_byte_en(dmem_byte_en),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.br_taken(br_taken),
		.br_target(br_target),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.cc(cc)
	);

endmodule : lc3b_pipeline

// File: testbench/lc3b_tb.sv
module lc3b_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Program layout in instruction slots
	localparam logic [15:0] start_pc = 16'h0040;
	localparam int base = int'(start_pc[8:1]);
	localparam int rand_count = 40;
	localparam int last_idx = 16 + rand_count;
	localparam int prog_len = last_idx + 2;
	localparam logic [15:0] loop_pc = start_pc + 16'(2 * (prog_len - 1));
	localparam int timeout_cycles = 2 * prog_len + 20;

	logic clk = 1'b0;
	logic rst;
	logic [15:0] imem_addr;
	logic [15:0] imem_rdata;
	logic [15:0] dmem_addr;
	logic dmem_read;
	logic dmem_write;
	logic [1:0] dmem_byte_en;
	logic [15:0] dmem_wdata;
	logic [15:0] dmem_rdata;
	logic wb_valid;
	logic [2:0] wb_dest;
	logic [15:0] wb_data;
	logic [2:0] cc;

	// Memories seen by the DUT
	logic [15:0] imem [256];
	logic [7:0] dmem [256];

	// Shadow ISA state
	logic [15:0] ref_regs [8];
	logic [7:0] ref_mem [256];
	logic [15:0] ref_pc;
	logic [2:0] ref_cc;

	// Expected effect of the next retiring instruction
	logic exp_wr;
	logic [2:0] exp_dest;
	logic [15:0] exp_data;
	logic exp_st;
	logic [15:0] exp_addr;
	logic [15:0] exp_wdata;
	logic [1:0] exp_be;
	logic exp_ld;
	logic cc_pending;
	logic [2:0] cc_expect;
	logic done;

	integer seed = 32'hf12f_ecc9;
	int cycles = 0;

	lc3b_pipeline #(
		.reset_pc(start_pc)
	) uut (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_byte_en(dmem_byte_en),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.cc(cc)
	);

	always #5 clk = ~clk;

	// Both memories answer in the same cycle, little-endian words
	assign imem_rdata = imem[imem_addr[8:1]];
	assign dmem_rdata = {dmem[{dmem_addr[7:1], 1'b1}], dmem[{dmem_addr[7:1], 1'b0}]};

	// Odd multiplier, so every byte address gets its own value
	function automatic logic [7:0] fill_byte(input int a);
		logic [7:0] low;
		low = 8'(a);
		return low * 8'd29 + 8'h4b;
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// One instruction of the LC-3b subset on the shadow state
	function automatic void step_ref(output logic wr, output logic [2:0] dest,
			output logic [15:0] wval, output logic st, output logic [15:0] saddr,
			output logic [15:0] sdata, output logic [1:0] sbe, output logic ld);
		logic [15:0] inst;
		logic [15:0] pc_inc;
		logic [15:0] sra;
		logic [15:0] srb;
		logic [15:0] off9;
		logic [15:0] addr;
		inst = imem[ref_pc[8:1]];
		pc_inc = ref_pc + 16'd2;
		sra = ref_regs[inst[8:6]];
		// imm5 or SR2
		srb = inst[5] ? {{11{inst[4]}}, inst[4:0]} : ref_regs[inst[2:0]];
		off9 = {{6{inst[8]}}, inst[8:0], 1'b0};
		addr = 16'h0000;
		wr = 1'b0;
		st = 1'b0;
		ld = 1'b0;
		dest = inst[11:9];
		wval = 16'h0000;
		saddr = 16'h0000;
		sdata = ref_regs[inst[11:9]];
		sbe = 2'b00;
		ref_pc = pc_inc;
		case (inst[15:12])
			4'b0001: begin
				wr = 1'b1;
				wval = sra + srb;
			end
			4'b0101: begin
				wr = 1'b1;
				wval = sra & srb;
			end
			4'b1001: begin
				wr = 1'b1;
				wval = ~sra;
			end
			4'b0110: begin
				// LDR, word aligned
				addr = sra + {{9{inst[5]}}, inst[5:0], 1'b0};
				wr = 1'b1;
				ld = 1'b1;
				wval = {ref_mem[{addr[7:1], 1'b1}], ref_mem[{addr[7:1], 1'b0}]};
			end
			4'b0010: begin
				addr = sra + {{10{inst[5]}}, inst[5:0]};
				wr = 1'b1;
				ld = 1'b1;
				wval = {8'h00, ref_mem[addr[7:0]]};
			end
			4'b0111: begin
				addr = sra + {{9{inst[5]}}, inst[5:0], 1'b0};
				st = 1'b1;
				saddr = {addr[15:1], 1'b0};
				sbe = 2'b11;
				ref_mem[{addr[7:1], 1'b0}] = sdata[7:0];
				ref_mem[{addr[7:1], 1'b1}] = sdata[15:8];
			end
			4'b0011: begin
				// STB, byte copied onto both lanes
				addr = sra + {{10{inst[5]}}, inst[5:0]};
				st = 1'b1;
				saddr = addr;
				sbe = addr[0] ? 2'b10 : 2'b01;
				ref_mem[addr[7:0]] = sdata[7:0];
				sdata = {sdata[7:0], sdata[7:0]};
			end
			4'b1101: begin
				wr = 1'b1;
				if (!inst[4])
					wval = sra << inst[3:0];
				else if (!inst[5])
					wval = sra >> inst[3:0];
				else begin
					// Vacated high bits take the sign
					wval = sra >> inst[3:0];
					if (sra[15])
						wval = wval | ~(16'hffff >> inst[3:0]);
				end
			end
			4'b1110: begin
				wr = 1'b1;
				wval = pc_inc + off9;
			end
			4'b0000: begin
				if ((inst[11:9] & ref_cc) != 3'b000)
					ref_pc = pc_inc + off9;
			end
			default: begin
			end
		endcase
		if (wr) begin
			ref_regs[dest] = wval;
			// Exactly one of n, z, p
			if (wval == 16'h0000)
				ref_cc = 3'b010;
			else if (wval[15])
				ref_cc = 3'b100;
			else
				ref_cc = 3'b001;
		end
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [15:0] inst;
		logic [2:0] dr;
		logic [2:0] sa;
		logic [2:0] sb;
		int kind;
		int off;
		// Never-taken BR everywhere else
		for (int i = 0; i < 256; i++)
			imem[i] = {8'h00, 8'(i)};
		// Clear then seed each register
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			imem[8'(base + 2 * i)] = {4'b0101, 3'(i), 3'(i), 1'b1, 5'b00000};
			imem[8'(base + 2 * i + 1)] = {4'b0001, 3'(i), 3'(i), 1'b1, r[4:0]};
		end
		for (int idx = 16; idx < last_idx; idx++) begin
			r = $random(seed);
			kind = int'(r[31:24]) % 11;
			dr = r[2:0];
			sa = r[5:3];
			sb = r[8:6];
			case (kind)
				0: inst = r[18] ? {4'b0001, dr, sa, 1'b1, r[13:9]} : {4'b0001, dr, sa, 3'b000, sb};
				1: inst = r[18] ? {4'b0101, dr, sa, 1'b1, r[13:9]} : {4'b0101, dr, sa, 3'b000, sb};
				2: inst = {4'b1001, dr, sa, 6'b111111};
				3: inst = {4'b0110, dr, sa, r[14:9]};
				4: inst = {4'b0010, dr, sa, r[14:9]};
				5: inst = {4'b0111, dr, sa, r[14:9]};
				6: inst = {4'b0011, dr, sa, r[14:9]};
				7: inst = {4'b1101, dr, sa, r[20:19], r[12:9]};
				8: inst = {4'b1110, dr, r[17:9]};
				default: begin
					// Forward only, never past the final ADD
					off = int'(r[10:9]);
					if (idx + 1 + off > last_idx)
						off = last_idx - idx - 1;
					inst = {4'b0000, r[23:21], 9'(off)};
				end
			endcase
			imem[8'(base + idx)] = inst;
		end
		imem[8'(base + last_idx)] = {4'b0001, 3'd7, 3'd7, 1'b1, 5'd1};
		// BRnzp to itself
		imem[8'(base + last_idx + 1)] = {4'b0000, 3'b111, 9'h1ff};
	endtask

	initial begin
		rst = 1'b1;
		build_program();
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
	end

	// Data memory, stores land mid-cycle
	always @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= fill_byte(i);
		end else if (dmem_write) begin
			if (dmem_byte_en[0])
				dmem[{dmem_addr[7:1], 1'b0}] <= dmem_wdata[7:0];
			if (dmem_byte_en[1])
				dmem[{dmem_addr[7:1], 1'b1}] <= dmem_wdata[15:8];
		end
	end

	// In-order comparison of retired effects
	always @(negedge clk) begin
		if (rst) begin
			check("wb_valid in reset", 16'h0000, 16'(wb_valid));
			check("dmem_write in reset", 16'h0000, 16'(dmem_write));
			check("dmem_read in reset", 16'h0000, 16'(dmem_read));
			check("cc in reset", 16'h0002, 16'(cc));
			check("imem_addr in reset", start_pc, imem_addr);
			ref_pc = start_pc;
			ref_cc = 3'b010;
			cc_pending = 1'b0;
			done = 1'b0;
			for (int i = 0; i < 8; i++)
				ref_regs[i] = 16'h0000;
			for (int i = 0; i < 256; i++)
				ref_mem[i] = fill_byte(i);
		end else begin
			// cc register updated at the edge after a write
			if (cc_pending) begin
				check("cc", 16'(cc_expect), 16'(cc));
				cc_pending = 1'b0;
			end
			if (done) begin
				$display("TB PASSED");
				$finish;
			end else if (wb_valid || dmem_write) begin
				exp_wr = 1'b0;
				exp_st = 1'b0;
				exp_ld = 1'b0;
				// Skip branches and squashed-free no-ops
				while (!exp_wr && !exp_st && ref_pc != loop_pc) begin
					step_ref(exp_wr, exp_dest, exp_data, exp_st, exp_addr, exp_wdata, exp_be,
						exp_ld);
				end
				if (!exp_wr && !exp_st) begin
					$display("DUT wrote back or stored after the last program instruction");
					$display("TB FAILED");
					$fatal(1, "unexpected writeback or store");
				end else begin
					check("wb_valid", 16'(exp_wr), 16'(wb_valid));
					check("dmem_write", 16'(exp_st), 16'(dmem_write));
					check("dmem_read", 16'(exp_ld), 16'(dmem_read));
					if (exp_wr) begin
						check("wb_dest", 16'(exp_dest), 16'(wb_dest));
						check("wb_data", exp_data, wb_data);
						cc_expect = ref_cc;
						cc_pending = 1'b1;
					end
					if (exp_st) begin
						check("dmem_addr", exp_addr, dmem_addr);
						check("dmem_wdata", exp_wdata, dmem_wdata);
						check("dmem_byte_en", 16'(exp_be), 16'(dmem_byte_en));
					end
					done = (ref_pc == loop_pc);
				end
			end else begin
				// Every load writes a register
				check("dmem_read without writeback", 16'h0000, 16'(dmem_read));
			end
		end
	end

	// Run length bound
	always @(posedge clk) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("TB FAILED");
			$fatal(1, "timeout, program did not finish");
		end
	end

endmodule : lc3b_tb

// File: flist.f
rtl/lc3b_types.sv
rtl/control_rom.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/lc3b_pipeline.sv
testbench/lc3b_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module lc3b_tb -f flist.f -o lc3b_sim \
	&& ./obj_dir/lc3b_sim \
	|| exit 1
